// ==== logic/rp_pkg.sv ====
// Analog data path package
// Widths, stream and bus types, register map and the
// converter code helpers shared by the front and back end
`default_nettype none

package rp_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned ADC_IN_W = 16;  // Raw ADC bus, 2 LSBs reserved
  localparam int unsigned ADC_W    = 14;  // Stream sample
  localparam int unsigned SUM_W    = 15;  // Sum before saturation
  localparam int unsigned SYS_AW   = 20;  // System bus address
  localparam int unsigned SYS_DW   = 32;  // System bus data
  localparam int unsigned PWM_CH   = 4;   // PWM outputs
  localparam int unsigned PWM_W    = 8;   // PWM level

  // Vector types
  typedef logic        [ADC_IN_W-1:0] adc_raw_t;
  typedef logic        [ADC_W-1:0]    dac_code_t;  // Offset, negative slope
  typedef logic signed [ADC_W-1:0]    sample_t;
  typedef logic signed [SUM_W-1:0]    sum_t;
  typedef logic        [SYS_AW-1:0]   sys_addr_t;
  typedef logic        [SYS_DW-1:0]   sys_data_t;
  typedef logic        [PWM_W-1:0]    pwm_level_t;

  // Grouped signals
  typedef struct packed { sample_t   a; sample_t   b; } chan_pair_t;
  typedef struct packed { adc_raw_t  a; adc_raw_t  b; } adc_pair_t;
  typedef struct packed { dac_code_t a; dac_code_t b; } dac_pair_t;

  typedef struct packed {
    sys_addr_t addr;
    sys_data_t wdata;
    logic      wen;   // One-cycle write strobe
    logic      ren;   // One-cycle read strobe
  } sys_req_t;

  typedef struct packed {
    sys_data_t rdata;
    logic      ack;
    logic      err;   // Unmapped address
  } sys_rsp_t;

  typedef struct packed {
    pwm_level_t [PWM_CH-1:0] level;
  } pwm_cfg_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam sys_data_t BOARD_ID    = 32'h0A14_2A10;
  localparam sys_addr_t REG_ID      = 20'h00000;  // RO
  localparam sys_addr_t REG_DIGLOOP = 20'h00004;  // Bit 0 loopback
  localparam sys_addr_t REG_PWM0    = 20'h00020;
  localparam sys_addr_t REG_PWM1    = 20'h00024;
  localparam sys_addr_t REG_PWM2    = 20'h00028;
  localparam sys_addr_t REG_PWM3    = 20'h0002C;

  // Offset negative-slope code to two's complement
  // Keep MSB, invert the rest; the mapping is its own inverse
  function automatic sample_t code_to_sample(dac_code_t code);
    return {code[ADC_W-1], ~code[ADC_W-2:0]};
  endfunction

  function automatic dac_code_t sample_to_code(sample_t smp);
    return {smp[ADC_W-1], ~smp[ADC_W-2:0]};
  endfunction

endpackage : rp_pkg

`default_nettype wire

// ==== logic/sys_regs.sv ====
// System bus register block
// Housekeeping registers (board ID, digital loopback) and the
// four PWM level registers behind one decoder
// Response is registered, ack one cycle after the strobe
`timescale 1ns/1ps
`default_nettype none

module sys_regs (
  input  wire logic             arst_n_i,
  input  wire logic             adc_clk,
  input  rp_pkg::sys_req_t      sys_req_i,     // Bus request
  output rp_pkg::sys_rsp_t      sys_rsp_o,     // Registered response
  output      logic             digital_loop_o,
  output rp_pkg::pwm_cfg_t      pwm_cfg_o
);

  import rp_pkg::*;

  //////////////////////////////
  // Local signals
  //////////////////////////////

  logic      strobe;         // Any access this cycle
  logic      unmapped;       // Address outside the map
  sys_data_t rdata_d;        // Read mux
  sys_data_t rdata_q;
  logic      ack_q;
  logic      err_q;
  logic      loop_q;         // Loopback enable
  pwm_cfg_t  pwm_cfg_q;      // PWM levels

  assign strobe = sys_req_i.wen | sys_req_i.ren;

  // Address decode and read data
  always_comb
  begin
    rdata_d  = '0;
    unmapped = 1'b0;
    case (sys_req_i.addr)
      REG_ID:      rdata_d = BOARD_ID;
      REG_DIGLOOP: rdata_d = sys_data_t'(loop_q);
      REG_PWM0:    rdata_d = sys_data_t'(pwm_cfg_q.level[0]);  // Upper bits zero
      REG_PWM1:    rdata_d = sys_data_t'(pwm_cfg_q.level[1]);
      REG_PWM2:    rdata_d = sys_data_t'(pwm_cfg_q.level[2]);
      REG_PWM3:    rdata_d = sys_data_t'(pwm_cfg_q.level[3]);
      default:     unmapped = 1'b1;
    endcase
  end

  //////////////////////////////
  // Register writes
  //////////////////////////////

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      loop_q    <= 1'b0;
      pwm_cfg_q <= '0;  // All outputs low
    end
    else if (sys_req_i.wen)
    begin
      // ID and unmapped writes fall through
      case (sys_req_i.addr)
        REG_DIGLOOP: loop_q             <= sys_req_i.wdata[0];
        REG_PWM0:    pwm_cfg_q.level[0] <= sys_req_i.wdata[PWM_W-1:0];
        REG_PWM1:    pwm_cfg_q.level[1] <= sys_req_i.wdata[PWM_W-1:0];
        REG_PWM2:    pwm_cfg_q.level[2] <= sys_req_i.wdata[PWM_W-1:0];
        REG_PWM3:    pwm_cfg_q.level[3] <= sys_req_i.wdata[PWM_W-1:0];
        default:     ;
      endcase
    end
  end

  //////////////////////////////
  // Response
  //////////////////////////////

  // Ack and err pulse one cycle after each strobe
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end
    else
    begin
      ack_q <= strobe;
      err_q <= strobe & unmapped;
    end
  end

  // Read data, zero on writes
  always_ff @(posedge adc_clk)
  begin
    if (strobe)
      rdata_q <= sys_req_i.ren ? rdata_d : '0;
  end

  assign sys_rsp_o.rdata = rdata_q;
  assign sys_rsp_o.ack   = ack_q;
  assign sys_rsp_o.err   = err_q;

  assign digital_loop_o  = loop_q;
  assign pwm_cfg_o       = pwm_cfg_q;

endmodule : sys_regs

`default_nettype wire

// ==== logic/adc_frontend.sv ====
// ADC front end
// Registers both ADC buses, drops the reserved LSBs and turns
// the negative-slope offset code into two's complement
// Digital loopback swaps in the DAC sum stream
`timescale 1ns/1ps
`default_nettype none

module adc_frontend (
  input  wire logic          arst_n_i,
  input  wire logic          adc_clk,
  input  rp_pkg::adc_pair_t  adc_dat_i,       // Raw converter buses
  input  wire logic          digital_loop_i,
  input  rp_pkg::chan_pair_t dac_sum_i,       // Saturated DAC sums
  output rp_pkg::chan_pair_t adc_dat_o
);

  import rp_pkg::*;

  dac_code_t  raw_a_q;   // Upper 14 bits, CH A
  dac_code_t  raw_b_q;   // Upper 14 bits, CH B
  chan_pair_t adc_conv;

  // Input register, 2 LSBs reserved on the 16-bit bus
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      raw_a_q <= '0;
      raw_b_q <= '0;
    end
    else
    begin
      raw_a_q <= adc_dat_i.a[ADC_IN_W-1:ADC_IN_W-ADC_W];
      raw_b_q <= adc_dat_i.b[ADC_IN_W-1:ADC_IN_W-ADC_W];
    end
  end

  assign adc_conv.a = code_to_sample(raw_a_q);  // Sign kept, rest inverted
  assign adc_conv.b = code_to_sample(raw_b_q);

  // Loopback path is combinational, same cycle as the DAC inputs
  assign adc_dat_o = digital_loop_i ? dac_sum_i : adc_conv;

endmodule : adc_frontend

`default_nettype wire

// ==== logic/dac_backend.sv ====
// DAC back end
// Adds generator and controller streams per channel, saturates
// the 15-bit sum to 14 bits and registers the converter code
// in offset negative-slope format
`timescale 1ns/1ps
`default_nettype none

module dac_backend (
  input  wire logic          arst_n_i,
  input  wire logic          adc_clk,
  input  rp_pkg::chan_pair_t asg_dat_i,   // Generator stream
  input  rp_pkg::chan_pair_t pid_dat_i,   // Controller stream
  output rp_pkg::chan_pair_t dac_sum_o,   // Saturated sums, combinational
  output rp_pkg::dac_pair_t  dac_dat_o    // Registered DAC codes
);

  import rp_pkg::*;

  //////////////////////////////
  // Sum and saturation
  //////////////////////////////

  // Top two sum bits differ on overflow
  function automatic sample_t sat_add(sample_t x, sample_t y);
    sum_t s;
    s = sum_t'(x) + sum_t'(y);  // Sign extended
    if (s[SUM_W-1] != s[SUM_W-2])
      return {s[SUM_W-1], {(ADC_W-1){~s[SUM_W-1]}}};  // +8191 or -8192
    else
      return s[ADC_W-1:0];
  endfunction

  chan_pair_t dac_sum;
  dac_pair_t  dac_q;

  assign dac_sum.a = sat_add(asg_dat_i.a, pid_dat_i.a);
  assign dac_sum.b = sat_add(asg_dat_i.b, pid_dat_i.b);

  //////////////////////////////
  // Output register
  //////////////////////////////

  // 0x1FFF is the zero-volt code
  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      dac_q.a <= 14'h1FFF;
      dac_q.b <= 14'h1FFF;
    end
    else
    begin
      dac_q.a <= sample_to_code(dac_sum.a);
      dac_q.b <= sample_to_code(dac_sum.b);
    end
  end

  assign dac_sum_o = dac_sum;
  assign dac_dat_o = dac_q;

endmodule : dac_backend

`default_nettype wire

// ==== logic/pwm_dac.sv ====
// PWM DAC
// Four 8-bit PWM modulators on one free-running period counter
// Levels are taken at the period start and hold for the period
`timescale 1ns/1ps
`default_nettype none

module pwm_dac (
  input  wire logic                 arst_n_i,
  input  wire logic                 adc_clk,
  input  rp_pkg::pwm_cfg_t          pwm_cfg_i,  // Levels from the register block
  output logic [rp_pkg::PWM_CH-1:0] pwm_o
);

  import rp_pkg::*;

  pwm_level_t              cnt_q;    // Period counter, 0..255
  pwm_cfg_t                lvl_q;    // Levels for the running period
  pwm_cfg_t                lvl_sel;  // Level used this cycle
  logic       [PWM_CH-1:0] pwm_q;

  // New level straight from the config at counter 0
  assign lvl_sel = (cnt_q == '0) ? pwm_cfg_i : lvl_q;

  always_ff @(posedge adc_clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      cnt_q <= '0;
      lvl_q <= '0;
      pwm_q <= '0;
    end
    else
    begin
      cnt_q <= cnt_q + 1'b1;  // Wraps at 255
      lvl_q <= lvl_sel;
      for (int i = 0; i < PWM_CH; i++)
        pwm_q[i] <= cnt_q < lvl_sel.level[i];  // High for level cycles of 256
    end
  end

  assign pwm_o = pwm_q;

endmodule : pwm_dac

`default_nettype wire

// ==== logic/rp_analog_top.sv ====
// Two-channel analog data path, top level
// ADC front end with digital loopback, DAC back end with
// saturation, system-bus registers and four PWM outputs
// Single clock domain
`timescale 1ns/1ps
`default_nettype none

module rp_analog_top (
  input  wire logic                 arst_n_i,
  input  wire logic                 adc_clk,
  // System bus
  input  rp_pkg::sys_req_t          sys_req_i,
  output rp_pkg::sys_rsp_t          sys_rsp_o,
  // ADC
  input  rp_pkg::adc_pair_t         adc_dat_i,  // Raw converter buses
  // Streams
  input  rp_pkg::chan_pair_t        asg_dat_i,  // Generator samples
  input  rp_pkg::chan_pair_t        pid_dat_i,  // Controller samples
  output rp_pkg::chan_pair_t        adc_dat_o,  // To scope and controller
  // DAC
  output rp_pkg::dac_pair_t         dac_dat_o,
  // PWM
  output logic [rp_pkg::PWM_CH-1:0] pwm_o
);

  import rp_pkg::*;

  //////////////////////////////
  // Local signals
  //////////////////////////////

  logic       digital_loop;  // ADC stream replaced by DAC stream
  pwm_cfg_t   pwm_cfg;
  chan_pair_t dac_sum;       // Saturated sums for loopback

  //////////////////////////////
  // Housekeeping and PWM regs
  //////////////////////////////

  sys_regs i_sys_regs (
    .arst_n_i       (arst_n_i),
    .adc_clk        (adc_clk),
    .sys_req_i      (sys_req_i),
    .sys_rsp_o      (sys_rsp_o),
    .digital_loop_o (digital_loop),
    .pwm_cfg_o      (pwm_cfg)
  );

  //////////////////////////////
  // ADC and DAC
  //////////////////////////////

  adc_frontend i_adc_frontend (
    .arst_n_i       (arst_n_i),
    .adc_clk        (adc_clk),
    .adc_dat_i      (adc_dat_i),
    .digital_loop_i (digital_loop),
    .dac_sum_i      (dac_sum),
    .adc_dat_o      (adc_dat_o)
  );

  dac_backend i_dac_backend (
    .arst_n_i  (arst_n_i),
    .adc_clk   (adc_clk),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_sum_o (dac_sum),
    .dac_dat_o (dac_dat_o)
  );

  //////////////////////////////
  // PWM outputs
  //////////////////////////////

  pwm_dac i_pwm_dac (
    .arst_n_i  (arst_n_i),
    .adc_clk   (adc_clk),
    .pwm_cfg_i (pwm_cfg),
    .pwm_o     (pwm_o)
  );

endmodule : rp_analog_top

`default_nettype wire

// ==== test/tb_rp_analog.sv ====
// Testbench for the two-channel analog data path
// Stream and bus tables applied in loops, loopback and PWM duty
// Expected values come from reference models of the codes
`timescale 1ns/1ps
`default_nettype none

module tb_rp_analog;

  import rp_pkg::*;

  localparam int     STREAM_N  = 16;  // 8 fixed, 8 random
  localparam int     BUS_N     = 13;
  localparam int     RESET_CYC = 10;
  localparam longint LIMIT_NS  = ((STREAM_N + BUS_N) * 300 + RESET_CYC) * 10;

  typedef struct {
    adc_pair_t  adc;
    chan_pair_t asg;
    chan_pair_t pid;
    chan_pair_t exp_adc;    // Converted ADC, loopback off
    chan_pair_t exp_sum;    // Saturated sum, loopback on
    dac_pair_t  exp_dac;
  } stream_vec_t;

  typedef struct {
    logic      wen;
    logic      ren;
    sys_addr_t addr;
    sys_data_t wdata;
    sys_data_t exp_rdata;   // Reads only
    logic      exp_err;
  } bus_op_t;

  logic              adc_clk;
  logic              arst_n_i;
  sys_req_t          sys_req;
  sys_rsp_t          sys_rsp;
  adc_pair_t         adc_dat;
  chan_pair_t        asg_dat;
  chan_pair_t        pid_dat;
  chan_pair_t        adc_out;
  dac_pair_t         dac_out;
  logic [PWM_CH-1:0] pwm;

  stream_vec_t streams [STREAM_N];
  bus_op_t     bus_ops [BUS_N];
  int unsigned seed_ret;

  rp_analog_top DUT (
    .arst_n_i  (arst_n_i),
    .adc_clk   (adc_clk),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp),
    .adc_dat_i (adc_dat),
    .asg_dat_i (asg_dat),
    .pid_dat_i (pid_dat),
    .adc_dat_o (adc_out),
    .dac_dat_o (dac_out),
    .pwm_o     (pwm)
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 100 MHz
  end

  // Watchdog
  initial
  begin
    #(LIMIT_NS);
    $display("Timeout: simulation still running after %0d ns", LIMIT_NS);
    $display("TB FAILED");
    $fatal(1);
  end

  //////////////////////////////
  // Reference models
  //////////////////////////////

  // Upper 14 bits, code 0 is +8191 and 0x3FFF is -8192
  function automatic sample_t adc_model(adc_raw_t raw);
    int code;
    code = int'(raw[15:2]);
    return sample_t'(8191 - code);
  endfunction

  function automatic sample_t sat_sum(sample_t x, sample_t y);
    int s;
    s = int'(x) + int'(y);
    if (s > 8191)
      s = 8191;   // Positive clamp
    else if (s < -8192)
      s = -8192;
    return sample_t'(s);
  endfunction

  function automatic dac_code_t code_of_sample(sample_t s);
    return dac_code_t'(8191 - int'(s));  // Zero volts at 0x1FFF
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_sample(input string name, input sample_t exp, input sample_t act);
    if (act !== exp)
    begin
      $display("FAILED at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_dac(input string name, input dac_code_t exp, input dac_code_t act);
    if (act !== exp)
    begin
      $display("FAILED at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bus(input string name, input sys_data_t exp, input sys_data_t act);
    if (act !== exp)
    begin
      $display("FAILED at %0t ns: %s expected 0x%h, got 0x%h", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      $display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
      $display("TB FAILED");
      $fatal(1);
    end
  endtask

  //////////////////////////////
  // Tables
  //////////////////////////////

  function automatic bus_op_t make_op(logic wen, logic ren, sys_addr_t addr,
                                      sys_data_t wdata, sys_data_t rdata, logic err);
    bus_op_t op;
    op.wen       = wen;
    op.ren       = ren;
    op.addr      = addr;
    op.wdata     = wdata;
    op.exp_rdata = rdata;
    op.exp_err   = err;
    return op;
  endfunction

  task automatic load_stream(input int idx, input adc_raw_t aa, input adc_raw_t ab,
                             input int ga, input int gb, input int pa, input int pb);
    stream_vec_t v;
    v.adc.a     = aa;
    v.adc.b     = ab;
    v.asg.a     = sample_t'(ga);
    v.asg.b     = sample_t'(gb);
    v.pid.a     = sample_t'(pa);
    v.pid.b     = sample_t'(pb);
    v.exp_adc.a = adc_model(aa);
    v.exp_adc.b = adc_model(ab);
    v.exp_sum.a = sat_sum(v.asg.a, v.pid.a);
    v.exp_sum.b = sat_sum(v.asg.b, v.pid.b);
    v.exp_dac.a = code_of_sample(v.exp_sum.a);
    v.exp_dac.b = code_of_sample(v.exp_sum.b);
    streams[idx] = v;
  endtask

  task automatic fill_tables();
    load_stream(0, 16'h0000, 16'hFFFF, 0, 0, 0, 0);
    load_stream(1, 16'h8000, 16'h7FFC, 8191, -8192, 1, -1);          // Both overflows
    load_stream(2, 16'h1234, 16'hABCD, 5000, -5000, 4000, -4000);
    load_stream(3, 16'h4003, 16'hC001, 100, -3, -50, 3);
    load_stream(4, 16'h3FFC, 16'hBFFC, 8191, -8192, 8191, -8192);    // Max overflow
    load_stream(5, 16'h0004, 16'hFFF8, 8191, 4095, -8192, 4096);     // Edge, no clamp
    load_stream(6, 16'h7FFF, 16'h8003, -4096, 1, -4096, -1);
    load_stream(7, 16'h5A5A, 16'hA5A5, 0, 0, -1, 1);
    for (int i = 8; i < STREAM_N; i++)
      load_stream(i, adc_raw_t'($urandom()), adc_raw_t'($urandom()), int'($urandom()),
                  int'($urandom()), int'($urandom()), int'($urandom()));
    bus_ops[0]  = make_op(1'b0, 1'b1, REG_ID, 32'h0, BOARD_ID, 1'b0);
    bus_ops[1]  = make_op(1'b1, 1'b0, REG_PWM0, 32'hABCD_1200, 32'h0, 1'b0);
    bus_ops[2]  = make_op(1'b1, 1'b0, REG_PWM1, 32'h0000_0140, 32'h0, 1'b0);
    bus_ops[3]  = make_op(1'b1, 1'b0, REG_PWM2, 32'h5555_55C8, 32'h0, 1'b0);
    bus_ops[4]  = make_op(1'b1, 1'b0, REG_PWM3, 32'h0000_00FF, 32'h0, 1'b0);
    bus_ops[5]  = make_op(1'b0, 1'b1, REG_PWM0, 32'h0, 32'h0000_0000, 1'b0);
    bus_ops[6]  = make_op(1'b0, 1'b1, REG_PWM1, 32'h0, 32'h0000_0040, 1'b0);
    bus_ops[7]  = make_op(1'b0, 1'b1, REG_PWM2, 32'h0, 32'h0000_00C8, 1'b0);
    bus_ops[8]  = make_op(1'b0, 1'b1, REG_PWM3, 32'h0, 32'h0000_00FF, 1'b0);
    bus_ops[9]  = make_op(1'b0, 1'b1, 20'h00010, 32'h0, 32'h0, 1'b1);           // Unmapped
    bus_ops[10] = make_op(1'b1, 1'b0, 20'h00030, 32'h1234_5678, 32'h0, 1'b1);
    bus_ops[11] = make_op(1'b1, 1'b0, REG_ID, 32'hDEAD_BEEF, 32'h0, 1'b0);      // RO
    bus_ops[12] = make_op(1'b0, 1'b1, REG_ID, 32'h0, BOARD_ID, 1'b0);
  endtask

  //////////////////////////////
  // Drivers and monitors
  //////////////////////////////

  // One strobe, response due one cycle later as a one-cycle pulse
  task automatic bus_access(input bus_op_t op);
    @(negedge adc_clk);
    sys_req.addr  = op.addr;
    sys_req.wdata = op.wdata;
    sys_req.wen   = op.wen;
    sys_req.ren   = op.ren;
    @(negedge adc_clk);
    sys_req.wen = 1'b0;
    sys_req.ren = 1'b0;
    check_bit("sys_rsp_o.ack", 1'b1, sys_rsp.ack);
    check_bit("sys_rsp_o.err", op.exp_err, sys_rsp.err);
    if (op.ren && !op.exp_err)
      check_bus("sys_rsp_o.rdata", op.exp_rdata, sys_rsp.rdata);
    @(negedge adc_clk);
    check_bit("sys_rsp_o.ack", 1'b0, sys_rsp.ack);  // Pulse over
  endtask

  // Drive each vector, then check the registered paths against the
  // previous vector and the loopback against the current one
  task automatic run_streams(input logic loop);
    chan_pair_t exp;
    for (int i = 0; i <= STREAM_N; i++)
    begin
      @(negedge adc_clk);
      if (i < STREAM_N)
      begin
        adc_dat = streams[i].adc;
        asg_dat = streams[i].asg;
        pid_dat = streams[i].pid;
      end
      #1;  // Combinational paths settled
      if (loop && i < STREAM_N)
      begin
        exp = streams[i].exp_sum;  // Same cycle
        check_sample("adc_dat_o.a", exp.a, adc_out.a);
        check_sample("adc_dat_o.b", exp.b, adc_out.b);
      end
      else if (!loop && i > 0)
      begin
        exp = streams[i-1].exp_adc;  // One cycle late
        check_sample("adc_dat_o.a", exp.a, adc_out.a);
        check_sample("adc_dat_o.b", exp.b, adc_out.b);
      end
      if (i > 0)
      begin
        check_dac("dac_dat_o.a", streams[i-1].exp_dac.a, dac_out.a);
        check_dac("dac_dat_o.b", streams[i-1].exp_dac.b, dac_out.b);
      end
    end
  endtask

  // Levels as written by the bus table
  task automatic measure_pwm();
    int unsigned high_cnt [PWM_CH];
    pwm_level_t  level    [PWM_CH];
    level = '{8'd0, 8'd64, 8'd200, 8'd255};
    foreach (high_cnt[i])
      high_cnt[i] = 0;
    repeat (512) @(negedge adc_clk);  // Two full periods
    repeat (256)
    begin
      @(negedge adc_clk);
      for (int i = 0; i < PWM_CH; i++)
        high_cnt[i] = high_cnt[i] + int'(pwm[i]);
    end
    for (int i = 0; i < PWM_CH; i++)
      check_bus($sformatf("pwm_o[%0d] high cycles", i), sys_data_t'(level[i]),
                sys_data_t'(high_cnt[i]));
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial
  begin
    seed_ret = $urandom(32'h48ab_446c);
    arst_n_i = 1'b0;
    sys_req  = '0;
    adc_dat  = '0;
    asg_dat  = '0;
    pid_dat  = '0;
    fill_tables();
    repeat (RESET_CYC) @(posedge adc_clk);
    @(negedge adc_clk);
    arst_n_i = 1'b1;
    #1;
    for (int i = 0; i < PWM_CH; i++)
      check_bit($sformatf("pwm_o[%0d]", i), 1'b0, pwm[i]);
    check_dac("dac_dat_o.a", 14'h1FFF, dac_out.a);  // Zero volts
    check_dac("dac_dat_o.b", 14'h1FFF, dac_out.b);
    for (int i = 0; i < BUS_N; i++)
      bus_access(bus_ops[i]);  // ID read comes first
    measure_pwm();
    run_streams(1'b0);
    bus_access(make_op(1'b1, 1'b0, REG_DIGLOOP, 32'h1, 32'h0, 1'b0));
    bus_access(make_op(1'b0, 1'b1, REG_DIGLOOP, 32'h0, 32'h1, 1'b0));
    run_streams(1'b1);
    bus_access(make_op(1'b1, 1'b0, REG_DIGLOOP, 32'h0, 32'h0, 1'b0));
    run_streams(1'b0);  // Back on the ADC
    $display("TB PASSED");
    $finish;
  end

endmodule : tb_rp_analog

`default_nettype wire

// ==== build.f ====
logic/rp_pkg.sv
logic/sys_regs.sv
logic/adc_frontend.sv
logic/dac_backend.sv
logic/pwm_dac.sv
logic/rp_analog_top.sv
test/tb_rp_analog.sv

// ==== Makefile ====
# Verilator flow for the two-channel analog data path
TOOL     = verilator
FLAGS    = --timing
TOP      = tb_rp_analog
FILELIST = build.f
OBJDIR   = obj_dir
PASS_MSG = TB PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

# Pass only if the simulation prints the pass line
sim: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
